/* rtl/ifu_macros.svh */
`ifndef IFU_MACROS_SVH
`define IFU_MACROS_SVH

// Fetch starts here after reset
`define IFU_PC_INIT 32'h8000_0000

// Direct-mapped L1I: 4 sets of 2-word lines
`define IFU_SETS       4
`define IFU_IDX_W      2
`define IFU_LINE_WORDS 2
`define IFU_OFS_W      1
`define IFU_TAG_W      27  // 32 - idx - ofs - byte bits

// RV32I major opcodes
`define IFU_OP_JAL    7'b110_1111
`define IFU_OP_JALR   7'b110_0111
`define IFU_OP_BRANCH 7'b110_0011
`define IFU_OP_SYSTEM 7'b111_0011
`define IFU_OP_LOAD   7'b000_0011

// fence.i with rd = rs1 = 0, imm = 0
`define IFU_INST_FENCE_I 32'h0000_100f

`endif

/* rtl/ifu_pkg.sv */
`include "ifu_macros.svh"

package ifu_pkg;

  typedef logic [31:0] addr_t;  // Byte address
  typedef logic [31:0] inst_t;

  typedef logic [`IFU_TAG_W-1:0] tag_t;
  typedef logic [`IFU_IDX_W-1:0] idx_t;
  typedef logic [`IFU_OFS_W-1:0] ofs_t;  // Word within line

  // Handed to the backend with valid_o
  typedef struct packed {
    addr_t pc;
    inst_t inst;
  } fetch_out_t;

  // One refill word going into the array
  typedef struct packed {
    idx_t  idx;
    tag_t  tag;
    ofs_t  ofs;
    inst_t data;
  } refill_t;

  typedef enum logic [1:0] {
    ST_LOOKUP,
    ST_REQ,
    ST_WAIT,
    ST_STALL
  } fetch_state_e;

endpackage

/* rtl/ifu_fetch_fsm.sv */
`timescale 1ns/1ps
`include "ifu_macros.svh"

module ifu_fetch_fsm (
  input  logic                clk,
  input  logic                rst,
  input  logic                ready_i,
  input  logic                redirect_i,
  input  ifu_pkg::addr_t      redirect_pc_i,
  input  logic                hit_i,
  input  ifu_pkg::inst_t      hit_inst_i,
  input  ifu_pkg::inst_t      rdata_i,
  input  logic                rvalid_i,
  input  ifu_pkg::ofs_t       ofs_i,
  input  logic                last_i,
  output ifu_pkg::addr_t      pc_o,
  output ifu_pkg::fetch_out_t fetch_o,
  output logic                valid_o,
  output ifu_pkg::addr_t      araddr_o,
  output logic                arvalid_o,
  output ifu_pkg::refill_t    beat_o,
  output logic                beat_we_o,
  output logic                start_o,
  output logic                flush_o
);

  ifu_pkg::fetch_state_e state_q;
  ifu_pkg::fetch_state_e state_d;
  ifu_pkg::addr_t        pc_q;
  ifu_pkg::addr_t        pc_d;
  logic [6:0]            opcode;
  logic                  is_stall;
  logic                  is_fence;
  logic                  accept;

  assign opcode = hit_inst_i[6:0];

  // Control flow and loads wait for the backend to redirect
  assign is_stall = (opcode == `IFU_OP_JAL)    ||
                    (opcode == `IFU_OP_JALR)   ||
                    (opcode == `IFU_OP_BRANCH) ||
                    (opcode == `IFU_OP_SYSTEM) ||
                    (opcode == `IFU_OP_LOAD);
  assign is_fence = (hit_inst_i == `IFU_INST_FENCE_I);

  assign valid_o = (state_q == ifu_pkg::ST_LOOKUP) && hit_i;
  assign accept  = valid_o && ready_i;

  assign fetch_o.pc   = pc_q;
  assign fetch_o.inst = hit_inst_i;

  assign pc_o    = pc_q;
  assign flush_o = accept && is_fence;  // Valid bits drop on the next edge
  assign start_o = (state_q == ifu_pkg::ST_LOOKUP) && !hit_i;

  // One-cycle request per word, word picked by the beat counter
  assign arvalid_o = (state_q == ifu_pkg::ST_REQ);
  assign araddr_o  = {pc_q[31:`IFU_OFS_W+2], ofs_i, 2'b00};

  assign beat_we_o   = (state_q == ifu_pkg::ST_WAIT) && rvalid_i;
  assign beat_o.idx  = pc_q[`IFU_OFS_W+2 +: `IFU_IDX_W];
  assign beat_o.tag  = pc_q[31 -: `IFU_TAG_W];
  assign beat_o.ofs  = ofs_i;
  assign beat_o.data = rdata_i;

  always_comb begin
    state_d = state_q;
    pc_d    = pc_q;
    case (state_q)
      ifu_pkg::ST_LOOKUP: begin
        if (!hit_i) begin
          state_d = ifu_pkg::ST_REQ;
        end else if (accept) begin
          if (is_stall) begin
            state_d = ifu_pkg::ST_STALL;  // PC holds until redirect
          end else begin
            pc_d = pc_q + 32'd4;
          end
        end
      end
      ifu_pkg::ST_REQ: begin
        state_d = ifu_pkg::ST_WAIT;
      end
      ifu_pkg::ST_WAIT: begin
        if (rvalid_i) begin
          state_d = last_i ? ifu_pkg::ST_LOOKUP : ifu_pkg::ST_REQ;
        end
      end
      ifu_pkg::ST_STALL: begin
        if (redirect_i) begin
          pc_d    = redirect_pc_i;
          state_d = ifu_pkg::ST_LOOKUP;
        end
      end
      default: begin
        state_d = ifu_pkg::ST_LOOKUP;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ifu_pkg::ST_LOOKUP;
      pc_q    <= `IFU_PC_INIT;
    end else begin
      state_q <= state_d;
      pc_q    <= pc_d;
    end
  end

endmodule

/* rtl/ifu_beat_counter.sv */
`timescale 1ns/1ps
`include "ifu_macros.svh"

module ifu_beat_counter (
  input  logic          clk,
  input  logic          rst,
  input  logic          start_i,
  input  logic          beat_i,
  output ifu_pkg::ofs_t ofs_o,
  output logic          last_o
);

  ifu_pkg::ofs_t cnt_q;

  // Restart from word 0 at each miss
  always_ff @(posedge clk) begin
    if (rst || start_i) begin
      cnt_q <= '0;
    end else if (beat_i) begin
      cnt_q <= ifu_pkg::ofs_t'(cnt_q + 1'b1);
    end
  end

  assign ofs_o  = cnt_q;
  assign last_o = (cnt_q == ifu_pkg::ofs_t'(`IFU_LINE_WORDS - 1));  // Beat on offer ends the line

endmodule

/* rtl/ifu_l1i_array.sv */
`timescale 1ns/1ps
`include "ifu_macros.svh"

module ifu_l1i_array (
  input  logic             clk,
  input  logic             rst,
  input  ifu_pkg::addr_t   lookup_addr_i,
  input  ifu_pkg::refill_t beat_i,
  input  logic             we_i,
  input  logic             flush_i,
  output logic             hit_o,
  output ifu_pkg::inst_t   inst_o
);

  ifu_pkg::inst_t        data_q [`IFU_SETS][`IFU_LINE_WORDS];
  ifu_pkg::tag_t         tag_q  [`IFU_SETS];
  logic [`IFU_SETS-1:0]  valid_q;

  ifu_pkg::tag_t lk_tag;
  ifu_pkg::idx_t lk_idx;
  ifu_pkg::ofs_t lk_ofs;
  logic          final_word;

  // Address split: tag | index | word | byte
  assign lk_tag = lookup_addr_i[31 -: `IFU_TAG_W];
  assign lk_idx = lookup_addr_i[`IFU_OFS_W+2 +: `IFU_IDX_W];
  assign lk_ofs = lookup_addr_i[2 +: `IFU_OFS_W];

  assign hit_o  = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
  assign inst_o = data_q[lk_idx][lk_ofs];

  assign final_word = (beat_i.ofs == ifu_pkg::ofs_t'(`IFU_LINE_WORDS - 1));

  always_ff @(posedge clk) begin
    if (we_i) begin
      data_q[beat_i.idx][beat_i.ofs] <= beat_i.data;
      tag_q[beat_i.idx]              <= beat_i.tag;
    end
  end

  // A partly refilled set must not hit, so earlier words clear the bit
  always_ff @(posedge clk) begin
    if (rst || flush_i) begin
      valid_q <= '0;
    end else if (we_i) begin
      valid_q[beat_i.idx] <= final_word;
    end
  end

endmodule

/* rtl/ifu_top.sv */
`timescale 1ns/1ps

module ifu_top (
  input  logic                clk,
  input  logic                rst,
  output ifu_pkg::addr_t      araddr_o,
  output logic                arvalid_o,
  input  ifu_pkg::inst_t      rdata_i,
  input  logic                rvalid_i,
  output ifu_pkg::fetch_out_t fetch_o,
  output logic                valid_o,
  input  logic                ready_i,
  input  logic                redirect_i,
  input  ifu_pkg::addr_t      redirect_pc_i
);

  ifu_pkg::addr_t   pc;
  ifu_pkg::inst_t   hit_inst;
  ifu_pkg::refill_t beat;
  ifu_pkg::ofs_t    ofs;
  logic             hit;
  logic             beat_we;
  logic             start;
  logic             flush;
  logic             last;

  ifu_fetch_fsm u_fsm (
    .clk           (clk),
    .rst           (rst),
    .ready_i       (ready_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .hit_i         (hit),
    .hit_inst_i    (hit_inst),
    .rdata_i       (rdata_i),
    .rvalid_i      (rvalid_i),
    .ofs_i         (ofs),
    .last_i        (last),
    .pc_o          (pc),
    .fetch_o       (fetch_o),
    .valid_o       (valid_o),
    .araddr_o      (araddr_o),
    .arvalid_o     (arvalid_o),
    .beat_o        (beat),
    .beat_we_o     (beat_we),
    .start_o       (start),
    .flush_o       (flush)
  );

  ifu_beat_counter u_cnt (
    .clk     (clk),
    .rst     (rst),
    .start_i (start),
    .beat_i  (beat_we),  // Counts each returned word
    .ofs_o   (ofs),
    .last_o  (last)
  );

  ifu_l1i_array u_l1i (
    .clk           (clk),
    .rst           (rst),
    .lookup_addr_i (pc),
    .beat_i        (beat),
    .we_i          (beat_we),
    .flush_i       (flush),
    .hit_o         (hit),
    .inst_o        (hit_inst)
  );

endmodule

/* tb/ifu_sva.sv */
`timescale 1ns/1ps

module ifu_sva (
  input logic                clk,
  input logic                rst,
  input logic                arvalid_i,
  input logic                rvalid_i,
  input ifu_pkg::fetch_out_t fetch_i,
  input logic                valid_i,
  input logic                ready_i
);

  int unsigned fail_cnt = 0;
  logic        pending_q;  // Request sent, data not back yet

  always_ff @(posedge clk) begin
    if (rst) begin
      pending_q <= 1'b0;
    end else if (arvalid_i) begin
      pending_q <= 1'b1;
    end else if (rvalid_i) begin
      pending_q <= 1'b0;
    end
  end

  hold_check: assert property (@(posedge clk) disable iff (rst)
    (valid_i && !ready_i) |=> (valid_i && $stable(fetch_i)))
  else begin
    $error("fetch output changed while stalled by ready_i");
    fail_cnt++;
  end

  no_req_check: assert property (@(posedge clk) disable iff (rst)
    (valid_i && !ready_i) |=> !arvalid_i)
  else begin
    $error("bus request made under back-pressure");
    fail_cnt++;
  end

  pulse_check: assert property (@(posedge clk) disable iff (rst) arvalid_i |=> !arvalid_i)
  else begin
    $error("arvalid high on two consecutive cycles");
    fail_cnt++;
  end

  one_out_check: assert property (@(posedge clk) disable iff (rst) arvalid_i |-> !pending_q)
  else begin
    $error("new request before the previous read returned");
    fail_cnt++;
  end

  reset_check: assert property (@(posedge clk) $fell(rst) |-> (!valid_i && !arvalid_i))
  else begin
    $error("valid or arvalid high in the first cycle after reset");
    fail_cnt++;
  end

endmodule

bind ifu_top ifu_sva u_sva (
  .clk       (clk),
  .rst       (rst),
  .arvalid_i (arvalid_o),
  .rvalid_i  (rvalid_i),
  .fetch_i   (fetch_o),
  .valid_i   (valid_o),
  .ready_i   (ready_i)
);

/* tb/ifu_tb.sv */
`timescale 1ns/1ps
`include "ifu_macros.svh"

module ifu_tb;

  localparam int FETCH_TARGET   = 300;
  localparam int TIMEOUT_CYCLES = 4000;  // ~300 fetches at worst miss cost, with margin

  logic                clk;
  logic                rst;
  ifu_pkg::addr_t      araddr_o;
  logic                arvalid_o;
  ifu_pkg::inst_t      rdata_i;
  logic                rvalid_i;
  ifu_pkg::fetch_out_t fetch_o;
  logic                valid_o;
  logic                ready_i;
  logic                redirect_i;
  ifu_pkg::addr_t      redirect_pc_i;

  logic                accept;
  ifu_pkg::addr_t      exp_pc;
  logic                stalled;
  logic [`IFU_SETS-1:0] need_req;  // Sets that must be refilled after a fence.i
  int                  jal_acc;
  int                  fence_cnt;
  int                  n_fetch;
  int                  cycle_cnt = 0;
  logic [31:0]         lfsr_q = 32'h0f47_9f08;

  ifu_top DUT (
    .clk           (clk),
    .rst           (rst),
    .araddr_o      (araddr_o),
    .arvalid_o     (arvalid_o),
    .rdata_i       (rdata_i),
    .rvalid_i      (rvalid_i),
    .fetch_o       (fetch_o),
    .valid_o       (valid_o),
    .ready_i       (ready_i),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32, 22, 2, 1
  endfunction

  function automatic int unsigned rand_bits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = (v << 1) | int'(lfsr_q[0]);
    end
    return v;
  endfunction

  // Memory contents as a function of the word address
  function automatic ifu_pkg::inst_t mem_word(input ifu_pkg::addr_t a);
    case (a[6:2])
      5'd7:    return {25'd0, `IFU_OP_JAL};
      5'd13:   return `IFU_INST_FENCE_I;
      5'd20:   return {25'd0, `IFU_OP_LOAD};
      default: return {a[13:2], 5'd0, 3'b000, 5'd0, 7'b001_0011};  // addi x0, x0, imm
    endcase
  endfunction

  function automatic logic stalls_fetch(input ifu_pkg::inst_t inst);
    return (inst[6:0] == `IFU_OP_JAL) || (inst[6:0] == `IFU_OP_LOAD);
  endfunction

  function automatic ifu_pkg::idx_t set_of(input ifu_pkg::addr_t a);
    return a[`IFU_OFS_W+2 +: `IFU_IDX_W];
  endfunction

  task automatic stop_with_failure();
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  assign accept = valid_o && ready_i;

  // Reference state built from the fetch rules
  always_ff @(posedge clk) begin
    if (rst) begin
      exp_pc    <= `IFU_PC_INIT;
      stalled   <= 1'b0;
      need_req  <= '0;
      jal_acc   <= 0;
      fence_cnt <= 0;
      n_fetch   <= 0;
    end else begin
      if (accept) begin
        n_fetch <= n_fetch + 1;
      end
      if (redirect_i) begin
        exp_pc  <= redirect_pc_i;
        stalled <= 1'b0;
      end else if (accept) begin
        if (stalls_fetch(fetch_o.inst)) begin
          stalled <= 1'b1;
        end else begin
          exp_pc <= exp_pc + 32'd4;
        end
      end
      if (accept && fetch_o.inst[6:0] == `IFU_OP_JAL) begin
        jal_acc <= jal_acc + 1;
      end
      if (accept && fetch_o.inst == `IFU_INST_FENCE_I) begin
        fence_cnt <= fence_cnt + 1;
        need_req  <= '1;
      end else if (arvalid_o) begin
        need_req[set_of(araddr_o)] <= 1'b0;
      end
    end
  end

  content_check: assert property (@(posedge clk) disable iff (rst)
    accept |-> (fetch_o.inst == mem_word(fetch_o.pc)))
  else begin
    $display("error content: expected %h actual %h",
             mem_word($sampled(fetch_o.pc)), $sampled(fetch_o.inst));
    stop_with_failure();
  end

  sequence_check: assert property (@(posedge clk) disable iff (rst)
    accept |-> (fetch_o.pc == exp_pc))
  else begin
    $display("error sequence: expected %h actual %h", $sampled(exp_pc), $sampled(fetch_o.pc));
    stop_with_failure();
  end

  stall_check: assert property (@(posedge clk) disable iff (rst) stalled |-> !valid_o)
  else begin
    $display("stall: valid_o went high before the redirect");
    stop_with_failure();
  end

  // Passes two and three run between the first and the third jal
  reuse_check: assert property (@(posedge clk) disable iff (rst)
    arvalid_o |-> !(jal_acc == 1 || jal_acc == 2))
  else begin
    $display("cache reuse: a cached line was requested again on a repeated pass");
    stop_with_failure();
  end

  flush_check: assert property (@(posedge clk) disable iff (rst)
    accept |-> !need_req[set_of(fetch_o.pc)])
  else begin
    $display("fence.i: a line was served from the cache without a new request");
    stop_with_failure();
  end

  // Memory answers each request after 1 to 4 cycles
  always begin : memory_model
    ifu_pkg::addr_t req_addr;
    int             delay;
    @(negedge clk);
    if (!rst && arvalid_o) begin
      req_addr = araddr_o;
      delay    = 1 + int'(rand_bits(2));
      @(posedge clk);
      repeat (delay - 1) @(posedge clk);
      #1;
      rdata_i  = mem_word(req_addr);
      rvalid_i = 1'b1;
      @(posedge clk);
      #1;
      rvalid_i = 1'b0;
    end
  end

  always begin : backend
    logic           stall_seen;
    ifu_pkg::addr_t stall_pc;
    ifu_pkg::inst_t stall_inst;
    int             gap;
    @(negedge clk);
    stall_seen = !rst && valid_o && ready_i && stalls_fetch(fetch_o.inst);
    stall_pc   = fetch_o.pc;
    stall_inst = fetch_o.inst;
    @(posedge clk);
    #1;
    if (stall_seen) begin
      gap = 1 + int'(rand_bits(2) % 3);
      repeat (gap - 1) @(posedge clk);
      #1;
      redirect_i = 1'b1;
      if (stall_inst[6:0] == `IFU_OP_JAL && jal_acc <= 2) begin
        redirect_pc_i = `IFU_PC_INIT;  // Refetch the first region
      end else begin
        redirect_pc_i = stall_pc + 32'd4;
      end
      @(posedge clk);
      #1;
      redirect_i = 1'b0;
    end else if (!rst) begin
      ready_i = (rand_bits(2) != 0);
    end
  end

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: %0d fetches not done after %0d cycles", FETCH_TARGET, cycle_cnt);
      stop_with_failure();
    end
    if (DUT.u_sva.fail_cnt != 0) begin
      $display("protocol: a bus or back-pressure assertion failed");
      stop_with_failure();
    end
  end

  initial begin
    rst           = 1'b1;
    ready_i       = 1'b0;
    redirect_i    = 1'b0;
    redirect_pc_i = '0;
    rdata_i       = '0;
    rvalid_i      = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    wait (n_fetch >= FETCH_TARGET);
    @(negedge clk);
    if (jal_acc < 3 || fence_cnt == 0) begin
      $display("coverage: the run missed the repeated passes or the fence.i");
      stop_with_failure();
    end else if (DUT.u_sva.fail_cnt != 0) begin
      $display("protocol: a bus or back-pressure assertion failed");
      stop_with_failure();
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

/* flist.f */
+incdir+rtl
rtl/ifu_pkg.sv
rtl/ifu_fetch_fsm.sv
rtl/ifu_beat_counter.sv
rtl/ifu_l1i_array.sv
rtl/ifu_top.sv
tb/ifu_sva.sv
tb/ifu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fetch unit testbench, then look for the pass line in the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module ifu_tb -f flist.f -o ifu_sim \
  && ./obj_dir/ifu_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2> /dev/null
grep -qx "Done: no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
